// File: rtl/ntt_butterfly_2x2.sv
// ML-DSA 2x2 NTT butterfly top level
// decode, two butterfly stages and output register, 8 cycles per item

`timescale 1ns/1ns
`include "ntt_defines.svh"

module ntt_butterfly_2x2 (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      valid_i,
    input  ntt_pkg::ntt_mode_e        mode_i,
    input  logic                      accumulate_i,
    input  logic [`NTT_COEFF_W-1:0]   u00_i, v00_i, u01_i, v01_i,
    input  logic [`NTT_COEFF_W-1:0]   w00_i, w01_i, w10_i, w11_i,
    input  logic [`NTT_COEFF_W-1:0]   pu0_i, pu1_i, pu2_i, pu3_i,
    input  logic [`NTT_COEFF_W-1:0]   pv0_i, pv1_i, pv2_i, pv3_i,
    input  logic [`NTT_COEFF_W-1:0]   pw0_i, pw1_i, pw2_i, pw3_i,
    output logic                      valid_o,
    output ntt_pkg::ntt_result_word_u data_o
);
    import ntt_pkg::*;

    // decode to execute
    logic                    dec_valid;
    ntt_mode_e               dec_mode;
    ntt_unit_op_e            op_s1, op_s2;
    logic [`NTT_COEFF_W-1:0] s1_u0, s1_v0, s1_w0, s1_u1, s1_v1, s1_w1;
    logic [`NTT_COEFF_W-1:0] s2_u0, s2_v0, s2_w0, s2_u1, s2_v1, s2_w1;

    // execute to result
    logic                    ex_valid;
    ntt_mode_e               ex_mode;
    logic [`NTT_COEFF_W-1:0] u20, v20, u21, v21;
    logic [`NTT_COEFF_W-1:0] pw0, pw1, pw2, pw3;

    ntt_decode u_decode (
        .clk(clk), .reset_n(reset_n),
        .valid_i(valid_i), .mode_i(mode_i), .accumulate_i(accumulate_i),
        .u00_i(u00_i), .v00_i(v00_i), .u01_i(u01_i), .v01_i(v01_i),
        .w00_i(w00_i), .w01_i(w01_i), .w10_i(w10_i), .w11_i(w11_i),
        .pu0_i(pu0_i), .pu1_i(pu1_i), .pu2_i(pu2_i), .pu3_i(pu3_i),
        .pv0_i(pv0_i), .pv1_i(pv1_i), .pv2_i(pv2_i), .pv3_i(pv3_i),
        .pw0_i(pw0_i), .pw1_i(pw1_i), .pw2_i(pw2_i), .pw3_i(pw3_i),
        .valid_o(dec_valid), .mode_o(dec_mode), .op_s1_o(op_s1), .op_s2_o(op_s2),
        .s1_u0_o(s1_u0), .s1_v0_o(s1_v0), .s1_w0_o(s1_w0),
        .s1_u1_o(s1_u1), .s1_v1_o(s1_v1), .s1_w1_o(s1_w1),
        .s2_u0_o(s2_u0), .s2_v0_o(s2_v0), .s2_w0_o(s2_w0),
        .s2_u1_o(s2_u1), .s2_v1_o(s2_v1), .s2_w1_o(s2_w1)
    );

    ntt_execute u_execute (
        .clk(clk), .reset_n(reset_n),
        .valid_i(dec_valid), .mode_i(dec_mode), .op_s1_i(op_s1), .op_s2_i(op_s2),
        .s1_u0_i(s1_u0), .s1_v0_i(s1_v0), .s1_w0_i(s1_w0),
        .s1_u1_i(s1_u1), .s1_v1_i(s1_v1), .s1_w1_i(s1_w1),
        .s2_u0_i(s2_u0), .s2_v0_i(s2_v0), .s2_w0_i(s2_w0),
        .s2_u1_i(s2_u1), .s2_v1_i(s2_v1), .s2_w1_i(s2_w1),
        .valid_o(ex_valid), .mode_o(ex_mode),
        .u20_o(u20), .v20_o(v20), .u21_o(u21), .v21_o(v21),
        .pw0_o(pw0), .pw1_o(pw1), .pw2_o(pw2), .pw3_o(pw3)
    );

    ntt_result u_result (
        .clk(clk), .reset_n(reset_n),
        .valid_i(ex_valid), .mode_i(ex_mode),
        .u20_i(u20), .v20_i(v20), .u21_i(u21), .v21_i(v21),
        .pw0_i(pw0), .pw1_i(pw1), .pw2_i(pw2), .pw3_i(pw3),
        .valid_o(valid_o), .data_o(data_o)
    );

endmodule

// File: rtl/ntt_butterfly_unit.sv
// modular butterfly / pointwise unit
// three registers: product, reduction mod q, final add or subtract

`timescale 1ns/1ns
`include "ntt_defines.svh"

module ntt_butterfly_unit (
    input  logic                      clk,
    input  logic                      reset_n,
    input  ntt_pkg::ntt_unit_op_e     op_i,
    input  logic [`NTT_COEFF_W-1:0]   u_i,
    input  logic [`NTT_COEFF_W-1:0]   v_i,
    input  logic [`NTT_COEFF_W-1:0]   w_i,
    output logic [`NTT_COEFF_W-1:0]   u_o,
    output logic [`NTT_COEFF_W-1:0]   v_o,
    output logic [`NTT_COEFF_W-1:0]   pw_o
);
    import ntt_pkg::*;

    localparam int W = `NTT_COEFF_W;

    // both operands are already below q
    function automatic logic [W-1:0] mod_add(input logic [W-1:0] a, input logic [W-1:0] b);
        logic [W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, `NTT_Q}) begin
            s = s - {1'b0, `NTT_Q};
        end
        return s[W-1:0];
    endfunction

    function automatic logic [W-1:0] mod_sub(input logic [W-1:0] a, input logic [W-1:0] b);
        logic [W:0] d;
        d = {1'b0, a} - {1'b0, b};
        if (a < b) begin
            d = d + {1'b0, `NTT_Q};
        end
        return d[W-1:0];
    endfunction

    logic [W-1:0]   mul_a, mul_b;
    logic [2*W-1:0] prod_rem;

    ntt_unit_op_e   op1, op2;
    logic [W-1:0]   u1, v1, w1;
    logic [2*W-1:0] prod1;
    logic [W-1:0]   u2, v2, w2, red2;

    // ct multiplies w*v, gs multiplies (u-v)*w, pointwise multiplies u*v
    always_comb begin
        mul_a = u_i;
        mul_b = v_i;
        if (op_i == op_ct) begin
            mul_a = w_i;
        end else if (op_i == op_gs) begin
            mul_a = mod_sub(u_i, v_i);
            mul_b = w_i;
        end
    end

    assign prod_rem = prod1 % {{W{1'b0}}, `NTT_Q};

    //------------------------------------------------------------
    // product and reduction registers
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            op1   <= op_ct;
            op2   <= op_ct;
            {u1, v1, w1, prod1} <= '0;
            {u2, v2, w2, red2}  <= '0;
        end else begin
            op1   <= op_i;
            u1    <= u_i;
            v1    <= v_i;
            w1    <= w_i;
            prod1 <= mul_a * mul_b;
            op2   <= op1;
            u2    <= u1;
            v2    <= v1;
            w2    <= w1;
            red2  <= prod_rem[W-1:0];
        end
    end

    //------------------------------------------------------------
    // final add/subtract register
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            {u_o, v_o, pw_o} <= '0;
        end else begin
            {u_o, v_o, pw_o} <= '0;
            case (op2)
                op_ct: begin
                    u_o <= mod_add(u2, red2);
                    v_o <= mod_sub(u2, red2);
                end
                op_gs: begin
                    u_o <= mod_add(u2, v2);
                    v_o <= red2;
                end
                op_mul:  pw_o <= red2;
                op_mac:  pw_o <= mod_add(red2, w2);
                op_add:  pw_o <= mod_add(u2, v2);
                op_sub:  pw_o <= mod_sub(u2, v2);
                default: pw_o <= '0;
            endcase
        end
    end

endmodule

// File: rtl/ntt_decode.sv
// NTT input stage
// registers one item, routes butterfly or pointwise operands and
// turns mode and accumulate into per-unit operations

`timescale 1ns/1ns
`include "ntt_defines.svh"

module ntt_decode (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      valid_i,
    input  ntt_pkg::ntt_mode_e        mode_i,
    input  logic                      accumulate_i,
    input  logic [`NTT_COEFF_W-1:0]   u00_i, v00_i, u01_i, v01_i,
    input  logic [`NTT_COEFF_W-1:0]   w00_i, w01_i, w10_i, w11_i,
    input  logic [`NTT_COEFF_W-1:0]   pu0_i, pu1_i, pu2_i, pu3_i,
    input  logic [`NTT_COEFF_W-1:0]   pv0_i, pv1_i, pv2_i, pv3_i,
    input  logic [`NTT_COEFF_W-1:0]   pw0_i, pw1_i, pw2_i, pw3_i,
    output logic                      valid_o,
    output ntt_pkg::ntt_mode_e        mode_o,
    output ntt_pkg::ntt_unit_op_e     op_s1_o,
    output ntt_pkg::ntt_unit_op_e     op_s2_o,
    output logic [`NTT_COEFF_W-1:0]   s1_u0_o, s1_v0_o, s1_w0_o,
    output logic [`NTT_COEFF_W-1:0]   s1_u1_o, s1_v1_o, s1_w1_o,
    output logic [`NTT_COEFF_W-1:0]   s2_u0_o, s2_v0_o, s2_w0_o,
    output logic [`NTT_COEFF_W-1:0]   s2_u1_o, s2_v1_o, s2_w1_o
);
    import ntt_pkg::*;

    logic         pw_mode;
    ntt_unit_op_e op_next;

    assign pw_mode = mode_i inside {pwm, pwa, pws};

    // accumulate only changes the pwm operation
    always_comb begin
        case (mode_i)
            ct:      op_next = op_ct;
            gs:      op_next = op_gs;
            pwm:     op_next = accumulate_i ? op_mac : op_mul;
            pwa:     op_next = op_add;
            pws:     op_next = op_sub;
            default: op_next = op_ct;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
            mode_o  <= ct;
            op_s1_o <= op_ct;
            op_s2_o <= op_ct;
            {s1_u0_o, s1_v0_o, s1_w0_o, s1_u1_o, s1_v1_o, s1_w1_o} <= '0;
            {s2_u0_o, s2_v0_o, s2_w0_o, s2_u1_o, s2_v1_o, s2_w1_o} <= '0;
        end else begin
            valid_o <= valid_i;
            mode_o  <= mode_i;
            op_s1_o <= op_next;
            op_s2_o <= op_next;
            if (pw_mode) begin
                // lanes 0 and 1 to stage 1, lanes 2 and 3 wait for stage 2
                {s1_u0_o, s1_v0_o, s1_w0_o} <= {pu0_i, pv0_i, pw0_i};
                {s1_u1_o, s1_v1_o, s1_w1_o} <= {pu1_i, pv1_i, pw1_i};
                {s2_u0_o, s2_v0_o, s2_w0_o} <= {pu2_i, pv2_i, pw2_i};
                {s2_u1_o, s2_v1_o, s2_w1_o} <= {pu3_i, pv3_i, pw3_i};
            end else begin
                {s1_u0_o, s1_v0_o, s1_w0_o} <= {u00_i, v00_i, w00_i};
                {s1_u1_o, s1_v1_o, s1_w1_o} <= {u01_i, v01_i, w01_i};
                // stage 2 u/v come from stage 1 results, only twiddles pass here
                {s2_u0_o, s2_v0_o, s2_w0_o} <= {{2*`NTT_COEFF_W{1'b0}}, w10_i};
                {s2_u1_o, s2_v1_o, s2_w1_o} <= {{2*`NTT_COEFF_W{1'b0}}, w11_i};
            end
        end
    end

endmodule

// File: rtl/ntt_defines.svh
// ML-DSA NTT butterfly block
// field width, modulus and pipeline latencies

`ifndef NTT_DEFINES_SVH
`define NTT_DEFINES_SVH

// coefficient width for q = 8380417
`define NTT_COEFF_W 23

// ML-DSA prime modulus
`define NTT_Q 23'd8380417

// one butterfly unit: product, reduce, final add/sub
`define NTT_UNIT_LAT 3

// decode + two unit stages + result register
`define NTT_TOTAL_LAT 8

`endif

// File: rtl/ntt_execute.sv
// two stages of two butterfly units
// stage 2 operands, lanes 0/1 results and item control are delayed
// so that each item leaves with its own mode

`timescale 1ns/1ns
`include "ntt_defines.svh"

module ntt_execute (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      valid_i,
    input  ntt_pkg::ntt_mode_e        mode_i,
    input  ntt_pkg::ntt_unit_op_e     op_s1_i,
    input  ntt_pkg::ntt_unit_op_e     op_s2_i,
    input  logic [`NTT_COEFF_W-1:0]   s1_u0_i, s1_v0_i, s1_w0_i,
    input  logic [`NTT_COEFF_W-1:0]   s1_u1_i, s1_v1_i, s1_w1_i,
    input  logic [`NTT_COEFF_W-1:0]   s2_u0_i, s2_v0_i, s2_w0_i,
    input  logic [`NTT_COEFF_W-1:0]   s2_u1_i, s2_v1_i, s2_w1_i,
    output logic                      valid_o,
    output ntt_pkg::ntt_mode_e        mode_o,
    output logic [`NTT_COEFF_W-1:0]   u20_o, v20_o, u21_o, v21_o,
    output logic [`NTT_COEFF_W-1:0]   pw0_o, pw1_o, pw2_o, pw3_o
);
    import ntt_pkg::*;

    localparam int W     = `NTT_COEFF_W;
    localparam int LAT   = `NTT_UNIT_LAT;
    localparam int OP_W  = $bits(ntt_unit_op_e);
    localparam int S2_W  = OP_W + 6 * W;
    localparam int CTL_W = 1 + $bits(ntt_mode_e);

    logic [LAT-1:0][S2_W-1:0]    s2_line;
    logic [2*LAT-1:0][CTL_W-1:0] ctl_line;
    logic [LAT-1:0][2*W-1:0]     pw01_line;

    // stage 1 results
    logic [W-1:0] u10, v10, u11, v11;
    logic [W-1:0] pw0_s1, pw1_s1;

    // stage 2 inputs after the delay line
    ntt_unit_op_e s2_op;
    logic         s2_bf;
    logic [W-1:0] s2_u0, s2_v0, s2_w0, s2_u1, s2_v1, s2_w1;
    logic [W-1:0] u10_in, v10_in, u11_in, v11_in;

    //------------------------------------------------------------
    // delay lines
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s2_line   <= '0;
            ctl_line  <= '0;
            pw01_line <= '0;
        end else begin
            s2_line   <= {s2_line[LAT-2:0],
                          {op_s2_i, s2_u0_i, s2_v0_i, s2_w0_i, s2_u1_i, s2_v1_i, s2_w1_i}};
            ctl_line  <= {ctl_line[2*LAT-2:0], {valid_i, mode_i}};
            // lanes 0/1 finish one stage early
            pw01_line <= {pw01_line[LAT-2:0], {pw0_s1, pw1_s1}};
        end
    end

    assign s2_op = ntt_unit_op_e'(s2_line[LAT-1][S2_W-1 -: OP_W]);
    assign {s2_u0, s2_v0, s2_w0, s2_u1, s2_v1, s2_w1} = s2_line[LAT-1][6*W-1:0];

    // butterflies feed stage 2 from stage 1, pointwise uses lanes 2/3
    assign s2_bf  = (s2_op == op_ct) || (s2_op == op_gs);
    assign u10_in = s2_bf ? u10 : s2_u0;
    assign v10_in = s2_bf ? v10 : s2_v0;
    assign u11_in = s2_bf ? u11 : s2_u1;
    assign v11_in = s2_bf ? v11 : s2_v1;

    //------------------------------------------------------------
    // butterfly units
    //------------------------------------------------------------
    ntt_butterfly_unit u_bf00 (
        .clk(clk), .reset_n(reset_n), .op_i(op_s1_i),
        .u_i(s1_u0_i), .v_i(s1_v0_i), .w_i(s1_w0_i),
        .u_o(u10), .v_o(u11), .pw_o(pw0_s1)
    );

    ntt_butterfly_unit u_bf01 (
        .clk(clk), .reset_n(reset_n), .op_i(op_s1_i),
        .u_i(s1_u1_i), .v_i(s1_v1_i), .w_i(s1_w1_i),
        .u_o(v10), .v_o(v11), .pw_o(pw1_s1)
    );

    ntt_butterfly_unit u_bf10 (
        .clk(clk), .reset_n(reset_n), .op_i(s2_op),
        .u_i(u10_in), .v_i(v10_in), .w_i(s2_w0),
        .u_o(u20_o), .v_o(v20_o), .pw_o(pw2_o)
    );

    ntt_butterfly_unit u_bf11 (
        .clk(clk), .reset_n(reset_n), .op_i(s2_op),
        .u_i(u11_in), .v_i(v11_in), .w_i(s2_w1),
        .u_o(u21_o), .v_o(v21_o), .pw_o(pw3_o)
    );

    assign {pw0_o, pw1_o} = pw01_line[LAT-1];
    assign valid_o        = ctl_line[2*LAT-1][CTL_W-1];
    assign mode_o         = ntt_mode_e'(ctl_line[2*LAT-1][CTL_W-2:0]);

endmodule

// File: rtl/ntt_pkg.sv
// ML-DSA NTT butterfly block
// item modes, per-unit operations and the output word

`include "ntt_defines.svh"

package ntt_pkg;

    // mode carried by each item
    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } ntt_mode_e;

    // what one butterfly unit does with its operands
    typedef enum logic [2:0] {
        op_ct  = 3'd0,
        op_gs  = 3'd1,
        op_mul = 3'd2,
        op_mac = 3'd3,
        op_add = 3'd4,
        op_sub = 3'd5
    } ntt_unit_op_e;

    // one output word, read as two butterfly pairs or four pointwise lanes
    typedef union packed {
        struct packed {
            logic [`NTT_COEFF_W-1:0] u20, v20, u21, v21;
        } bf;
        struct packed {
            logic [`NTT_COEFF_W-1:0] uv0, uv1, uv2, uv3;
        } pw;
    } ntt_result_word_u;

endpackage

// File: rtl/ntt_result.sv
// NTT output stage
// packs butterfly pairs or pointwise lanes into one word by mode

`timescale 1ns/1ns
`include "ntt_defines.svh"

module ntt_result (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      valid_i,
    input  ntt_pkg::ntt_mode_e        mode_i,
    input  logic [`NTT_COEFF_W-1:0]   u20_i, v20_i, u21_i, v21_i,
    input  logic [`NTT_COEFF_W-1:0]   pw0_i, pw1_i, pw2_i, pw3_i,
    output logic                      valid_o,
    output ntt_pkg::ntt_result_word_u data_o
);
    import ntt_pkg::*;

    ntt_result_word_u word_next;

    always_comb begin
        word_next = '0;
        if (mode_i inside {pwm, pwa, pws}) begin
            word_next.pw.uv0 = pw0_i;
            word_next.pw.uv1 = pw1_i;
            word_next.pw.uv2 = pw2_i;
            word_next.pw.uv3 = pw3_i;
        end else begin
            // ct and gs
            word_next.bf.u20 = u20_i;
            word_next.bf.v20 = v20_i;
            word_next.bf.u21 = u21_i;
            word_next.bf.v21 = v21_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
            data_o  <= '0;
        end else begin
            valid_o <= valid_i;
            data_o  <= word_next;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the NTT butterfly testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module ntt_tb -o ntt_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

# a raised error limit lets every failing assertion be reported
output=$(./obj_dir/ntt_sim +verilator+error+limit+100000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

// File: verif/ntt_assertions.sv
// reference checker for the 2x2 NTT butterfly
// rebuilds each output word from the inputs of 8 cycles before

`timescale 1ns/1ns
`include "ntt_defines.svh"

module ntt_assertions (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      valid_i,
    input  ntt_pkg::ntt_mode_e        mode_i,
    input  logic                      accumulate_i,
    input  logic [`NTT_COEFF_W-1:0]   u00_i, v00_i, u01_i, v01_i,
    input  logic [`NTT_COEFF_W-1:0]   w00_i, w01_i, w10_i, w11_i,
    input  logic [`NTT_COEFF_W-1:0]   pu0_i, pu1_i, pu2_i, pu3_i,
    input  logic [`NTT_COEFF_W-1:0]   pv0_i, pv1_i, pv2_i, pv3_i,
    input  logic [`NTT_COEFF_W-1:0]   pw0_i, pw1_i, pw2_i, pw3_i,
    input  logic                      valid_o,
    input  ntt_pkg::ntt_result_word_u data_o
);
    import ntt_pkg::*;

    localparam int     W   = `NTT_COEFF_W;
    localparam int     LAT = `NTT_TOTAL_LAT;
    localparam longint Q   = longint'(`NTT_Q);

    int fail_count = 0;

    logic           bf_item;
    logic [W-1:0]   u10, u11, v10, v11;
    logic [4*W-1:0] exp_word;
    logic [4*W-1:0] out_word;

    //------------------------------------------------------------
    // field arithmetic mod q
    //------------------------------------------------------------
    function automatic logic [W-1:0] madd(input logic [W-1:0] a, input logic [W-1:0] b);
        return W'((longint'(a) + longint'(b)) % Q);
    endfunction

    function automatic logic [W-1:0] msub(input logic [W-1:0] a, input logic [W-1:0] b);
        return W'((longint'(a) - longint'(b) + Q) % Q);
    endfunction

    function automatic logic [W-1:0] mmul(input logic [W-1:0] a, input logic [W-1:0] b);
        return W'((longint'(a) * longint'(b)) % Q);
    endfunction

    // {u + w*v, u - w*v}
    function automatic logic [2*W-1:0] ct_pair(input logic [W-1:0] u, input logic [W-1:0] v,
                                               input logic [W-1:0] w);
        return {madd(u, mmul(w, v)), msub(u, mmul(w, v))};
    endfunction

    // {u + v, (u - v)*w}
    function automatic logic [2*W-1:0] gs_pair(input logic [W-1:0] u, input logic [W-1:0] v,
                                               input logic [W-1:0] w);
        return {madd(u, v), mmul(msub(u, v), w)};
    endfunction

    function automatic logic [W-1:0] pw_lane(input ntt_mode_e m, input logic acc,
                                             input logic [W-1:0] u, input logic [W-1:0] v,
                                             input logic [W-1:0] w);
        case (m)
            pwa:     return madd(u, v);
            pws:     return msub(u, v);
            default: return acc ? madd(mmul(u, v), w) : mmul(u, v);
        endcase
    endfunction

    assign bf_item  = (mode_i == ct) || (mode_i == gs);
    assign out_word = data_o;

    // expected word for the item on the inputs right now
    always_comb begin
        u10 = '0;
        u11 = '0;
        v10 = '0;
        v11 = '0;
        if (mode_i == ct) begin
            {u10, u11} = ct_pair(u00_i, v00_i, w00_i);
            {v10, v11} = ct_pair(u01_i, v01_i, w01_i);
            exp_word   = {ct_pair(u10, v10, w10_i), ct_pair(u11, v11, w11_i)};
        end else if (mode_i == gs) begin
            {u10, u11} = gs_pair(u00_i, v00_i, w00_i);
            {v10, v11} = gs_pair(u01_i, v01_i, w01_i);
            exp_word   = {gs_pair(u10, v10, w10_i), gs_pair(u11, v11, w11_i)};
        end else begin
            exp_word = {pw_lane(mode_i, accumulate_i, pu0_i, pv0_i, pw0_i),
                        pw_lane(mode_i, accumulate_i, pu1_i, pv1_i, pw1_i),
                        pw_lane(mode_i, accumulate_i, pu2_i, pv2_i, pw2_i),
                        pw_lane(mode_i, accumulate_i, pu3_i, pv3_i, pw3_i)};
        end
    end

    //------------------------------------------------------------
    // output checks
    //------------------------------------------------------------
    valid_latency_a: assert property (@(posedge clk) disable iff (!reset_n)
        valid_o == $past(valid_i, LAT))
        else begin
            fail_count++;
            $error("mismatch at %0t: valid_o expected %0b got %0b",
                   $time, $past(valid_i, LAT), $sampled(valid_o));
        end

    bf_word_a: assert property (@(posedge clk) disable iff (!reset_n)
        $past(valid_i, LAT) && $past(bf_item, LAT) |-> out_word == $past(exp_word, LAT))
        else begin
            fail_count++;
            $error("mismatch at %0t: data_o.bf expected %h got %h",
                   $time, $past(exp_word, LAT), $sampled(out_word));
        end

    pw_word_a: assert property (@(posedge clk) disable iff (!reset_n)
        $past(valid_i, LAT) && !$past(bf_item, LAT) |-> out_word == $past(exp_word, LAT))
        else begin
            fail_count++;
            $error("mismatch at %0t: data_o.pw expected %h got %h",
                   $time, $past(exp_word, LAT), $sampled(out_word));
        end

endmodule

bind ntt_butterfly_2x2 ntt_assertions u_checks (
    .clk(clk), .reset_n(reset_n), .valid_i(valid_i), .mode_i(mode_i),
    .accumulate_i(accumulate_i),
    .u00_i(u00_i), .v00_i(v00_i), .u01_i(u01_i), .v01_i(v01_i),
    .w00_i(w00_i), .w01_i(w01_i), .w10_i(w10_i), .w11_i(w11_i),
    .pu0_i(pu0_i), .pu1_i(pu1_i), .pu2_i(pu2_i), .pu3_i(pu3_i),
    .pv0_i(pv0_i), .pv1_i(pv1_i), .pv2_i(pv2_i), .pv3_i(pv3_i),
    .pw0_i(pw0_i), .pw1_i(pw1_i), .pw2_i(pw2_i), .pw3_i(pw3_i),
    .valid_o(valid_o), .data_o(data_o)
);

// File: verif/ntt_tb.sv
// testbench for the ML-DSA 2x2 NTT butterfly
// random items of every mode, checked by the bound assertion module

`timescale 1ns/1ns
`include "ntt_defines.svh"

module ntt_tb;
    import ntt_pkg::*;

    localparam int          W          = `NTT_COEFF_W;
    localparam int          ITEMS      = 40;
    localparam int          TESTS      = 5;
    localparam int          MAX_CYCLES = (TESTS * ITEMS + `NTT_TOTAL_LAT) * 2;
    localparam int unsigned Q          = 32'(`NTT_Q);

    logic             clk;
    logic             reset_n;
    logic             in_valid;
    ntt_mode_e        in_mode;
    logic             in_acc;
    // u00, v00, u01, v01, w00, w01, w10, w11
    logic [W-1:0]     bf_in [8];
    logic [W-1:0]     pu [4];
    logic [W-1:0]     pv [4];
    logic [W-1:0]     pw [4];
    logic             out_valid;
    ntt_result_word_u out_data;

    integer seed;
    int     out_count    = 0;
    int     cycle_count  = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    int     total_errors = 0;

    ntt_butterfly_2x2 DUT (
        .clk(clk), .reset_n(reset_n),
        .valid_i(in_valid), .mode_i(in_mode), .accumulate_i(in_acc),
        .u00_i(bf_in[0]), .v00_i(bf_in[1]), .u01_i(bf_in[2]), .v01_i(bf_in[3]),
        .w00_i(bf_in[4]), .w01_i(bf_in[5]), .w10_i(bf_in[6]), .w11_i(bf_in[7]),
        .pu0_i(pu[0]), .pu1_i(pu[1]), .pu2_i(pu[2]), .pu3_i(pu[3]),
        .pv0_i(pv[0]), .pv1_i(pv[1]), .pv2_i(pv[2]), .pv3_i(pv[3]),
        .pw0_i(pw[0]), .pw1_i(pw[1]), .pw2_i(pw[2]), .pw3_i(pw[3]),
        .valid_o(out_valid), .data_o(out_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // outputs are counted mid cycle, away from the rising edge
    always @(negedge clk) begin
        if (reset_n && out_valid) begin
            out_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic int unsigned rand_below(input int unsigned n);
        int unsigned r;
        r = $random(seed);
        return r % n;
    endfunction

    task automatic randomize_operands();
        int k;
        for (k = 0; k < 8; k++) begin
            bf_in[k] = W'(rand_below(Q));
        end
        for (k = 0; k < 4; k++) begin
            pu[k] = W'(rand_below(Q));
            pv[k] = W'(rand_below(Q));
            pw[k] = W'(rand_below(Q));
        end
    endtask

    task automatic send_item(input ntt_mode_e m, input logic acc);
        @(negedge clk);
        in_valid = 1'b1;
        in_mode  = m;
        in_acc   = acc;
        randomize_operands();
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // kind 0 ct, 1 gs, 2 pwm, 3 pwa/pws, otherwise a random mix of all modes
    task automatic run_test(input string name, input int kind);
        int        n;
        int        fails_before;
        int        outs_before;
        int        fails;
        int        outs;
        ntt_mode_e m;
        fails_before = DUT.u_checks.fail_count;
        outs_before  = out_count;
        for (n = 0; n < ITEMS; n++) begin
            case (kind)
                0:       m = ct;
                1:       m = gs;
                2:       m = pwm;
                3:       m = (rand_below(2) == 0) ? pwa : pws;
                default: m = ntt_mode_e'(3'(rand_below(5)));
            endcase
            send_item(m, rand_below(2) == 1);
            // a few gaps so valid_o also has to drop between items
            if (kind == 0 && rand_below(4) == 0) begin
                idle_cycle();
            end
        end
        repeat (`NTT_TOTAL_LAT + 2) idle_cycle();
        fails = DUT.u_checks.fail_count - fails_before;
        outs  = out_count - outs_before;
        if (outs != ITEMS) begin
            $display("test %s: sent %0d items but saw %0d valid outputs", name, ITEMS, outs);
            fails++;
        end
        $display("test %s: %0d items, %0d outputs, %0d failures", name, ITEMS, outs, fails);
        tests_run++;
        total_errors += fails;
        if (fails != 0) begin
            tests_failed++;
        end
    endtask

    initial begin
        int k;
        int idle_fails;
        seed     = 822;
        reset_n  = 1'b0;
        in_valid = 1'b0;
        in_mode  = ct;
        in_acc   = 1'b0;
        for (k = 0; k < 8; k++) begin
            bf_in[k] = '0;
        end
        for (k = 0; k < 4; k++) begin
            pu[k] = '0;
            pv[k] = '0;
            pw[k] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // nothing may come out before the first item
        repeat (12) idle_cycle();
        idle_fails = DUT.u_checks.fail_count;
        if (out_count != 0) begin
            $display("idle: valid_o rose %0d times with no item sent", out_count);
            idle_fails++;
        end
        $display("test idle: %0d outputs, %0d failures", out_count, idle_fails);
        tests_run++;
        total_errors += idle_fails;
        if (idle_fails != 0) begin
            tests_failed++;
        end

        run_test("ct", 0);
        run_test("gs", 1);
        run_test("pwm", 2);
        run_test("pwa_pws", 3);
        run_test("mixed", 4);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/ntt_pkg.sv
rtl/ntt_decode.sv
rtl/ntt_butterfly_unit.sv
rtl/ntt_execute.sv
rtl/ntt_result.sv
rtl/ntt_butterfly_2x2.sv
verif/ntt_assertions.sv
verif/ntt_tb.sv
